// ==== build.f ====
source/mipsIsaPkg.sv
source/pipePkg.sv
source/registerFile.sv
source/decodeStage.sv
source/aluUnit.sv
source/executeStage.sv
source/resultStage.sv
source/mipsPipeline.sv
dv/clockGen.sv
dv/pipelineTb.sv

// ==== dv/pipelineTb.sv ====
`timescale 1ns/1ps

module pipelineTb
	import mipsIsaPkg::*;
();

	localparam int randomOps  = 300;  // R-type over preloaded registers
	localparam int chainReps  = 15;   // per forwarding distance
	localparam int mixedOps   = 40;   // bubble or illegal slot, then a read-back
	localparam int cycleLimit = 700;  // ~580 slots with reset and drain

	typedef struct packed {
		logic  valid;
		word_t result;
	} expSlot_t;

	logic     clk;
	logic     rst;
	instr_t   instr;
	logic     instrValid;
	word_t    aluResult;
	logic     aluValid;
	word_t    refRegs [32];  // architectural state in issue order
	expSlot_t expIssue;      // slot driven at this edge
	expSlot_t expPipe [2];   // lines up with the two-edge latency
	int       validErrs;
	int       resultErrs;
	int       cycleCount;

	clockGen clocks (
		.clk (clk),
		.rst (rst)
	);

	mipsPipeline uut (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.aluResult  (aluResult),
		.aluValid   (aluValid)
	);

	//////////////////////////////
	// encoding helpers
	//////////////////////////////

	function automatic instr_t rType(funct_t fn, regIdx_t rs, regIdx_t rt, regIdx_t rd);
		return {opR, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic instr_t iType(opcode_t op, regIdx_t rs, regIdx_t rt, imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic regIdx_t anyReg();
		return regIdx_t'($urandom_range(0, 31));
	endfunction

	function automatic regIdx_t nonZeroReg();
		return regIdx_t'($urandom_range(1, 31));
	endfunction

	function automatic funct_t anyFunct();
		case ($urandom_range(0, 4))
			0:       return functAdd;
			1:       return functSub;
			2:       return functAnd;
			3:       return functOr;
			default: return functNor;
		endcase
	endfunction

	// reference model runs at issue time, the pipeline never stalls
	task automatic issueSlot(input instr_t word, input logic live);
		expSlot_t slot;
		word_t    a;
		word_t    b;
		regIdx_t  dest;
		slot = '0;
		dest = word[15:11];            // rd for R-type
		a    = refRegs[word[25:21]];
		b    = refRegs[word[20:16]];
		if (live) begin
			case (word[31:26])
				opR: begin
					slot.valid = 1'b1;
					case (word[5:0])
						functAdd: slot.result = a + b;
						functSub: slot.result = a - b;
						functAnd: slot.result = a & b;
						functOr:  slot.result = a | b;
						functNor: slot.result = ~(a | b);
						default:  slot.valid  = 1'b0;  // unsupported funct
					endcase
				end
				opAddi: begin
					slot.valid  = 1'b1;
					slot.result = a + {{16{word[15]}}, word[15:0]};
					dest        = word[20:16];
				end
				opOri: begin
					slot.valid  = 1'b1;
					slot.result = a | {16'h0000, word[15:0]};
					dest        = word[20:16];
				end
				default: slot.valid = 1'b0;
			endcase
		end
		if (slot.valid && dest != 5'd0) begin
			refRegs[dest] = slot.result;  // r0 stays zero
		end
		@(posedge clk);
		instr      <= word;
		instrValid <= live;
		expIssue   <= slot;
	endtask

	//////////////////////////////
	// expected-result alignment
	//////////////////////////////

	always @(posedge clk) begin
		if (rst) begin
			expPipe[0] <= '0;
			expPipe[1] <= '0;
		end else begin
			expPipe[0] <= expIssue;
			expPipe[1] <= expPipe[0];
		end
	end

	aValidMatch: assert property (@(posedge clk) disable iff (rst)
		aluValid == expPipe[1].valid)
	else begin
		validErrs++;
		$display("ERR %0t: aluValid %b, expected %b", $time,
			$sampled(aluValid), $sampled(expPipe[1].valid));
	end

	aResultMatch: assert property (@(posedge clk) disable iff (rst)
		aluValid |-> aluResult == expPipe[1].result)
	else begin
		resultErrs++;
		$display("ERR %0t: aluResult %h, expected %h", $time,
			$sampled(aluResult), $sampled(expPipe[1].result));
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout: stimulus still running after %0d cycles", cycleLimit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		regIdx_t p;
		regIdx_t f;
		opcode_t op;
		funct_t  fn;
		void'($urandom(32'hdbac));
		instr      = '0;
		instrValid = 1'b0;
		expIssue   = '0;
		expPipe[0] = '0;
		expPipe[1] = '0;
		validErrs  = 0;
		resultErrs = 0;
		cycleCount = 0;
		for (int i = 0; i < 32; i++) begin
			refRegs[i] = '0;
		end
		while (rst !== 1'b0) @(posedge clk);

		repeat (3) issueSlot('0, 1'b0);  // idle, aluValid must stay low
		for (int r = 1; r < 32; r++) begin
			issueSlot(iType(opAddi, 5'd0, regIdx_t'(r), imm_t'($urandom())), 1'b1);
		end

		// immediate extension corners, then read-backs
		issueSlot(iType(opAddi, 5'd0, 5'd5, 16'hffff), 1'b1);
		issueSlot(iType(opOri, 5'd0, 5'd6, 16'h8000), 1'b1);
		issueSlot(iType(opAddi, 5'd0, 5'd7, 16'h8000), 1'b1);
		issueSlot(iType(opOri, 5'd7, 5'd8, 16'hffff), 1'b1);
		issueSlot(iType(opAddi, 5'd6, 5'd9, 16'hfffe), 1'b1);
		issueSlot(rType(functOr, 5'd5, 5'd0, 5'd10), 1'b1);
		issueSlot(rType(functOr, 5'd6, 5'd0, 5'd11), 1'b1);
		issueSlot(rType(functOr, 5'd7, 5'd0, 5'd12), 1'b1);
		issueSlot(rType(functAdd, 5'd8, 5'd9, 5'd13), 1'b1);

		for (int k = 0; k < randomOps; k++) begin
			issueSlot(rType(anyFunct(), anyReg(), anyReg(), anyReg()), 1'b1);
		end

		// producer, d-1 fillers, consumer
		for (int d = 1; d <= 3; d++) begin
			for (int k = 0; k < chainReps; k++) begin
				p = nonZeroReg();
				f = regIdx_t'((p % 31) + 1);  // never p, never r0
				issueSlot(iType(opAddi, anyReg(), p, imm_t'($urandom())), 1'b1);
				for (int g = 1; g < d; g++) begin
					issueSlot(rType(functOr, anyReg(), anyReg(), f), 1'b1);
				end
				if (k % 2 == 0) begin
					issueSlot(rType(functAdd, p, anyReg(), nonZeroReg()), 1'b1);  // rs path
				end else begin
					issueSlot(rType(functSub, anyReg(), p, nonZeroReg()), 1'b1);  // rt path
				end
			end
		end

		// writes to r0 must vanish, also within forwarding distance
		issueSlot(iType(opAddi, 5'd0, 5'd0, 16'h1234), 1'b1);
		issueSlot(iType(opOri, 5'd5, 5'd0, 16'h00ff), 1'b1);
		issueSlot(rType(functAdd, 5'd5, 5'd6, 5'd0), 1'b1);
		issueSlot(rType(functAdd, 5'd0, 5'd0, 5'd14), 1'b1);
		issueSlot(rType(functOr, 5'd0, 5'd5, 5'd15), 1'b1);

		for (int k = 0; k < mixedOps; k++) begin
			p = nonZeroReg();
			case ($urandom_range(0, 2))
				0: begin
					issueSlot(iType(opOri, anyReg(), p, imm_t'($urandom())), 1'b0);  // bubble
				end
				1: begin
					op = opcode_t'($urandom_range(1, 63));
					if (op == opAddi || op == opOri) begin
						op = 6'd35;  // lw, not kept
					end
					issueSlot(iType(op, anyReg(), p, imm_t'($urandom())), 1'b1);
				end
				default: begin
					fn = funct_t'($urandom_range(0, 63));
					if (fn inside {functAdd, functSub, functAnd, functOr, functNor}) begin
						fn = 6'd42;  // slt, not kept
					end
					issueSlot(rType(fn, anyReg(), anyReg(), p), 1'b1);
				end
			endcase
			issueSlot(rType(functOr, p, 5'd0, nonZeroReg()), 1'b1);  // p must be unchanged
		end

		repeat (4) issueSlot('0, 1'b0);  // drain
		repeat (2) @(posedge clk);
		$display("errors: aluValid %0d, aluResult %0d, total %0d",
			validErrs, resultErrs, validErrs + resultErrs);
		if (validErrs + resultErrs == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial begin
		rst = 1'b1;                  // held from time zero
		repeat (5) @(posedge clk);
		rst <= 1'b0;                 // released on the fifth edge
	end

endmodule

// ==== source/mipsPipeline.sv ====
`timescale 1ns/1ps

module mipsPipeline
	import mipsIsaPkg::*, pipePkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  instr_t instr,       // one instruction per edge
	input  logic   instrValid,  // low inserts a bubble
	output word_t  aluResult,
	output logic   aluValid
);

	decodedOp_t idEx;     // decode to execute
	retireOp_t  exMem;    // execute to result, forward source
	retireOp_t  memWb;    // write request, forward source
	regIdx_t    rdIdxA;
	regIdx_t    rdIdxB;
	word_t      rdDataA;
	word_t      rdDataB;

	//////////////////////////////
	// stages
	//////////////////////////////

	decodeStage decode (
		.clk        (clk),
		.rst        (rst),
		.instr      (instr),
		.instrValid (instrValid),
		.rdIdxA     (rdIdxA),
		.rdIdxB     (rdIdxB),
		.rdDataA    (rdDataA),
		.rdDataB    (rdDataB),
		.idEx       (idEx)
	);

	registerFile regFile (
		.clk     (clk),
		.rst     (rst),
		.rdIdxA  (rdIdxA),
		.rdIdxB  (rdIdxB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wr      (memWb)
	);

	executeStage execute (
		.clk       (clk),
		.rst       (rst),
		.idEx      (idEx),
		.exMem     (exMem),
		.memWb     (memWb),
		.aluResult (aluResult),  // visible at top as before
		.aluValid  (aluValid)
	);

	resultStage result (
		.clk   (clk),
		.rst   (rst),
		.exMem (exMem),
		.memWb (memWb)
	);

endmodule

// ==== source/resultStage.sv ====
`timescale 1ns/1ps

module resultStage
	import pipePkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  retireOp_t exMem,  // from execute
	output retireOp_t memWb   // write request and last forward point
);

	//////////////////////////////
	// MEM/WB register
	//////////////////////////////

	// no memory access left, so the slot only moves one stage on
	always_ff @(posedge clk) begin
		memWb.valid    <= exMem.valid;
		memWb.writeReg <= exMem.writeReg;  // destination register
		memWb.result   <= exMem.result;    // committed at the next edge
		if (rst) begin
			memWb.valid <= 1'b0;  // no write right after reset
		end
	end

	// a write request only shows up one edge after a live EX/MEM slot
	aFollowsExMem: assert property (@(posedge clk) disable iff (rst)
		memWb.valid |-> $past(exMem.valid));

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps

module executeStage
	import mipsIsaPkg::*, pipePkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  decodedOp_t idEx,
	output retireOp_t  exMem,      // EX/MEM register, first forward source
	input  retireOp_t  memWb,      // second forward source
	output word_t      aluResult,  // current slot, combinational
	output logic       aluValid
);

	word_t opA;   // forwarded rs
	word_t opB;   // forwarded rt
	word_t aluB;  // rt or immediate

	//////////////////////////////
	// forwarding
	//////////////////////////////

	// newest producer wins, register 0 never forwards
	function automatic word_t pickOperand(
		regIdx_t   idx,
		word_t     readVal,
		retireOp_t nearSrc,
		retireOp_t farSrc
	);
		if (nearSrc.valid && nearSrc.writeReg == idx && idx != '0)
			return nearSrc.result;  // one slot ahead
		if (farSrc.valid && farSrc.writeReg == idx && idx != '0)
			return farSrc.result;   // two slots ahead
		return readVal;             // from register file
	endfunction

	assign opA  = pickOperand(idEx.rs, idEx.rsValue, exMem, memWb);
	assign opB  = pickOperand(idEx.rt, idEx.rtValue, exMem, memWb);
	assign aluB = idEx.useImm ? idEx.immValue : opB;  // addi and ori

	aluUnit alu (
		.op     (idEx.aluOp),
		.a      (opA),
		.b      (aluB),
		.result (aluResult)
	);

	assign aluValid = idEx.valid;

	//////////////////////////////
	// EX/MEM register
	//////////////////////////////

	always_ff @(posedge clk) begin
		exMem.valid    <= idEx.valid;
		exMem.writeReg <= idEx.writeReg;
		exMem.result   <= aluResult;
		if (rst) begin
			exMem.valid <= 1'b0;
		end
	end

	// register file, forwarding and ALU together give a clean result
	aKnownResult: assert property (@(posedge clk) disable iff (rst)
		aluValid |-> !$isunknown(aluResult));

endmodule

// ==== source/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit
	import mipsIsaPkg::*;
(
	input  aluOp_t op,
	input  word_t  a,      // rs after forwarding
	input  word_t  b,      // rt or immediate
	output word_t  result
);

	always_comb begin
		case (op)
			aluAdd: begin
				result = a + b;  // wraps, no overflow trap
			end
			aluSub: begin
				result = a - b;
			end
			aluAnd: begin
				result = a & b;
			end
			aluOr: begin
				result = a | b;
			end
			aluNor: begin
				result = ~(a | b);
			end
			default: begin
				result = '0;  // not reachable from decode
			end
		endcase
	end

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage
	import mipsIsaPkg::*, pipePkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  instr_t     instr,
	input  logic       instrValid,
	output regIdx_t    rdIdxA,
	output regIdx_t    rdIdxB,
	input  word_t      rdDataA,
	input  word_t      rdDataB,
	output decodedOp_t idEx
);

	instr_t     ifIdInstr;  // IF/ID payload
	logic       ifIdValid;  // IF/ID slot live
	opcode_t    opcode;
	funct_t     funct;
	imm_t       imm;
	regIdx_t    rs;
	regIdx_t    rt;
	regIdx_t    rd;
	logic       legal;      // opcode and funct in the kept set
	decodedOp_t nextOp;     // ID/EX input

	//////////////////////////////
	// IF/ID register
	//////////////////////////////

	always_ff @(posedge clk) begin
		ifIdInstr <= instr;
		ifIdValid <= instrValid;  // low level gives a bubble
		if (rst) begin
			ifIdValid <= 1'b0;
		end
	end

	assign opcode = ifIdInstr[31:26];
	assign rs     = ifIdInstr[25:21];
	assign rt     = ifIdInstr[20:16];
	assign rd     = ifIdInstr[15:11];
	assign funct  = ifIdInstr[5:0];
	assign imm    = ifIdInstr[15:0];

	assign rdIdxA = rs;  // register read happens here
	assign rdIdxB = rt;

	always_comb begin
		nextOp          = '0;
		legal           = 1'b0;
		nextOp.aluOp    = aluAdd;
		nextOp.rs       = rs;
		nextOp.rt       = rt;
		nextOp.rsValue  = rdDataA;
		nextOp.rtValue  = rdDataB;
		nextOp.immValue = {{(wordWidth-immWidth){imm[immWidth-1]}}, imm};  // sign ext
		nextOp.writeReg = rd;
		case (opcode)
			opR: begin
				legal = 1'b1;
				case (funct)
					functAdd: nextOp.aluOp = aluAdd;
					functSub: nextOp.aluOp = aluSub;
					functAnd: nextOp.aluOp = aluAnd;
					functOr:  nextOp.aluOp = aluOr;
					functNor: nextOp.aluOp = aluNor;
					default:  legal = 1'b0;  // unsupported funct
				endcase
			end
			opAddi: begin
				legal           = 1'b1;
				nextOp.useImm   = 1'b1;
				nextOp.writeReg = rt;  // I-type destination
			end
			opOri: begin
				legal           = 1'b1;
				nextOp.aluOp    = aluOr;
				nextOp.useImm   = 1'b1;
				nextOp.immValue = {{(wordWidth-immWidth){1'b0}}, imm};  // zero ext
				nextOp.writeReg = rt;
			end
			default: legal = 1'b0;
		endcase
		nextOp.valid = ifIdValid && legal;  // illegal slot travels as a bubble
	end

	//////////////////////////////
	// ID/EX register
	//////////////////////////////

	always_ff @(posedge clk) begin
		idEx <= nextOp;
		if (rst) begin
			idEx.valid <= 1'b0;
		end
	end

	// a live decoded slot names a real operation
	aValidOp: assert property (@(posedge clk) disable iff (rst)
		idEx.valid |-> (!$isunknown(idEx.aluOp)
			&& (idEx.aluOp inside {aluAdd, aluSub, aluAnd, aluOr, aluNor})));

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile
	import mipsIsaPkg::*, pipePkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  regIdx_t   rdIdxA,   // rs from decode
	input  regIdx_t   rdIdxB,   // rt from decode
	output word_t     rdDataA,
	output word_t     rdDataB,
	input  retireOp_t wr        // MEM/WB write request
);

	word_t regs [regCount];  // regs[0] is never written

	// read port with same-cycle bypass of the pending write
	function automatic word_t readPort(regIdx_t idx, word_t stored, retireOp_t wrReq);
		if (idx == '0)
			return '0;  // hardwired zero
		if (wrReq.valid && wrReq.writeReg == idx)
			return wrReq.result;  // write-through
		return stored;
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;  // clean start
			end
		end else if (wr.valid && wr.writeReg != '0) begin
			regs[wr.writeReg] <= wr.result;
		end
	end

	assign rdDataA = readPort(rdIdxA, regs[rdIdxA], wr);
	assign rdDataB = readPort(rdIdxB, regs[rdIdxB], wr);

	// a retired write aimed at register 0 leaves it at zero
	aZeroReg: assert property (@(posedge clk) disable iff (rst)
		(wr.valid && wr.writeReg == '0) |=> (regs[0] == '0));

endmodule

// ==== source/pipePkg.sv ====
package pipePkg;

	import mipsIsaPkg::*;

	//////////////////////////////
	// decode to execute
	//////////////////////////////

	typedef struct packed {
		logic    valid;     // legal instruction in this slot
		aluOp_t  aluOp;     // operation for the ALU
		logic    useImm;    // second operand from immValue
		regIdx_t rs;        // first source, for forwarding
		regIdx_t rt;        // second source, for forwarding
		word_t   rsValue;   // value read in decode
		word_t   rtValue;
		word_t   immValue;  // already extended
		regIdx_t writeReg;  // rd or rt
	} decodedOp_t;

	//////////////////////////////
	// retire stages
	//////////////////////////////

	// finished result, also the write request and forward source
	typedef struct packed {
		logic    valid;     // slot writes a register
		regIdx_t writeReg;  // destination
		word_t   result;    // value to write
	} retireOp_t;

endpackage

// ==== source/mipsIsaPkg.sv ====
package mipsIsaPkg;

	//////////////////////////////
	// field widths
	//////////////////////////////

	localparam int wordWidth   = 32;                // datapath and instruction width
	localparam int regIdxWidth = 5;                 // rs, rt, rd fields
	localparam int regCount    = 1 << regIdxWidth;  // architectural registers
	localparam int opcodeWidth = 6;                 // bits 31..26
	localparam int functWidth  = 6;                 // bits 5..0 of R-type
	localparam int immWidth    = 16;                // bits 15..0 of I-type

	typedef logic [wordWidth-1:0]   word_t;         // register and ALU value
	typedef logic [regIdxWidth-1:0] regIdx_t;       // register number
	typedef logic [opcodeWidth-1:0] opcode_t;       // major opcode
	typedef logic [functWidth-1:0]  funct_t;        // R-type function code
	typedef logic [immWidth-1:0]    imm_t;          // raw immediate
	typedef logic [wordWidth-1:0]   instr_t;        // raw instruction word

	//////////////////////////////
	// encodings
	//////////////////////////////

	localparam opcode_t opR    = 6'd0;   // all R-type ops
	localparam opcode_t opAddi = 6'd8;   // sign-extended immediate
	localparam opcode_t opOri  = 6'd13;  // zero-extended immediate

	localparam funct_t functAdd = 6'd32;
	localparam funct_t functSub = 6'd34;
	localparam funct_t functAnd = 6'd36;
	localparam funct_t functOr  = 6'd37;
	localparam funct_t functNor = 6'd39;

	// operations the ALU knows about
	typedef enum logic [2:0] {
		aluAdd,  // add and addi
		aluSub,
		aluAnd,
		aluOr,   // or and ori
		aluNor
	} aluOp_t;

endpackage
